//--- hw/multipu_pkg.sv
// ################################################
// shared widths, unit count and enums for the
// cluster. every design file imports this package.
// ################################################

package multipu_pkg;

	// number of processing units sharing the memory port.
	localparam int PU_COUNT = 2;

	localparam int DATA_W = 16; // data and instruction width.
	localparam int ADDR_W = 14; // word address width.

	// index width for the arbiter grant, never below one bit.
	localparam int GRANT_W = (PU_COUNT > 1) ? $clog2(PU_COUNT) : 1;

	// instruction opcodes.
	// an instruction is {opcode, operand address}.
	typedef enum logic [1:0] {
		OP_LOAD  = 2'b00, // acc = mem[addr].
		OP_ADD   = 2'b01, // acc = acc + mem[addr].
		OP_STORE = 2'b10, // mem[addr] = acc.
		OP_HALT  = 2'b11  // stop fetching.
	} opcode_e;

	// bus operation carried with each request.
	typedef enum logic {
		PI1_READ  = 1'b0,
		PI1_WRITE = 1'b1
	} pi1_op_e;

	// controller states of one unit.
	typedef enum logic [1:0] {
		ST_FETCH  = 2'b00, // instruction read on the bus.
		ST_DECODE = 2'b01, // opcode is looked at.
		ST_MEM    = 2'b10, // operand read or write.
		ST_HALT   = 2'b11  // parked for good.
	} pu_state_e;

endpackage

//--- hw/pi1_if.sv
// ################################################
// one requester to arbiter memory link.
// units take the master side, the arbiter the slave.
// ################################################

interface pi1_if import multipu_pkg::*; ();

	logic              valid;
	logic              ready;
	pi1_op_e           op;
	logic [ADDR_W-1:0] addr;
	logic [DATA_W-1:0] wdata;
	logic [DATA_W-1:0] rdata; // only meaningful in the handshake cycle.

	modport master (
		output valid,
		output op,
		output addr,
		output wdata,
		input  ready,
		input  rdata
	);

	modport slave (
		input  valid,
		input  op,
		input  addr,
		input  wdata,
		output ready,
		output rdata
	);

endinterface

//--- hw/pu_ctrl.sv
// ################################################
// sequencer of one unit: fetch, decode, operand
// access and halt. steps end on the bus handshake.
// ################################################

module pu_ctrl import multipu_pkg::*; (
	input  logic      clk_i,
	input  logic      rst_n_i,
	input  logic      bus_ready_i,
	input  opcode_e   opcode_i,
	output pu_state_e state_o,
	output logic      ir_load_o,
	output logic      acc_en_o,
	output logic      pc_inc_o,
	output logic      halted_o
);

	pu_state_e state_q;
	pu_state_e state_d;

	always_comb begin
		state_d   = state_q;
		ir_load_o = 1'b0;
		acc_en_o  = 1'b0;
		pc_inc_o  = 1'b0;
		case (state_q)
			ST_FETCH: begin
				if (bus_ready_i) begin
					ir_load_o = 1'b1;
					pc_inc_o  = 1'b1;
					state_d   = ST_DECODE;
				end
			end
			ST_DECODE: begin
				if (opcode_i == OP_HALT) begin
					state_d = ST_HALT;
				end else begin
					state_d = ST_MEM;
				end
			end
			ST_MEM: begin
				if (bus_ready_i) begin
					// a store leaves the accumulator alone.
					acc_en_o = (opcode_i != OP_STORE);
					state_d  = ST_FETCH;
				end
			end
			ST_HALT: begin
				state_d = ST_HALT;
			end
			default: begin
				state_d = ST_FETCH;
			end
		endcase
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			state_q <= ST_FETCH;
		end else begin
			state_q <= state_d;
		end
	end

	assign state_o  = state_q;
	assign halted_o = (state_q == ST_HALT); // one cycle after the halt decode.

	// halt is terminal until the next reset.
	a_halt_sticky: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		state_q == ST_HALT |=> state_q == ST_HALT
	) else $error("unit left ST_HALT");

endmodule

//--- hw/pu_pc.sv
// ################################################
// program counter of one unit. loads the reset
// address in reset, steps one word per fetch.
// ################################################

module pu_pc import multipu_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [ADDR_W-1:0] rstaddr_i,
	input  logic              inc_i,
	output logic [ADDR_W-1:0] pc_o
);

	logic [ADDR_W-1:0] pc_q;

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			pc_q <= rstaddr_i; // start point comes from the top level.
		end else if (inc_i) begin
			pc_q <= pc_q + ADDR_W'(1);
		end
	end

	assign pc_o = pc_q;

endmodule

//--- hw/pu_alu.sv
// ################################################
// datapath of one unit: instruction register,
// accumulator and the 16-bit adder.
// ################################################

module pu_alu import multipu_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic              ir_load_i,
	input  opcode_e           acc_op_i,
	input  logic              acc_en_i,
	input  logic [DATA_W-1:0] rdata_i,
	output opcode_e           opcode_o,
	output logic [ADDR_W-1:0] operand_o,
	output logic [DATA_W-1:0] acc_o
);

	logic [DATA_W-1:0] ir_q;
	logic [DATA_W-1:0] acc_q;

	always_ff @(posedge clk_i) begin
		if (ir_load_i) begin
			ir_q <= rdata_i;
		end
	end

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			acc_q <= '0;
		end else if (acc_en_i) begin
			case (acc_op_i)
				OP_LOAD: acc_q <= rdata_i;
				OP_ADD:  acc_q <= acc_q + rdata_i; // wraps mod 2^16.
				default: acc_q <= acc_q;
			endcase
		end
	end

	assign opcode_o  = opcode_e'(ir_q[DATA_W-1 -: $bits(opcode_e)]);
	assign operand_o = ir_q[ADDR_W-1:0];
	assign acc_o     = acc_q;

endmodule

//--- hw/pu.sv
// ################################################
// one accumulator unit. controller, counter and
// datapath behind a single memory link.
// ################################################

module pu import multipu_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	input  logic [ADDR_W-1:0] rstaddr_i,
	output logic              halted_o,
	pi1_if.master             bus
);

	pu_state_e         state;
	opcode_e           opcode;
	logic [ADDR_W-1:0] pc;
	logic [ADDR_W-1:0] operand;
	logic [DATA_W-1:0] acc;
	logic              ir_load;
	logic              acc_en;
	logic              pc_inc;
	logic              handshake;
	logic              active_q;

	// holds off the first request for a cycle after reset.
	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			active_q <= 1'b0;
		end else begin
			active_q <= 1'b1;
		end
	end

	assign handshake = bus.valid && bus.ready;

	pu_ctrl u_ctrl (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.bus_ready_i (handshake),
		.opcode_i    (opcode),
		.state_o     (state),
		.ir_load_o   (ir_load),
		.acc_en_o    (acc_en),
		.pc_inc_o    (pc_inc),
		.halted_o    (halted_o)
	);

	pu_pc u_pc (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.rstaddr_i (rstaddr_i),
		.inc_i     (pc_inc),
		.pc_o      (pc)
	);

	pu_alu u_alu (
		.clk_i     (clk_i),
		.rst_n_i   (rst_n_i),
		.ir_load_i (ir_load),
		.acc_op_i  (opcode),
		.acc_en_i  (acc_en),
		.rdata_i   (bus.rdata),
		.opcode_o  (opcode),
		.operand_o (operand),
		.acc_o     (acc)
	);

	assign bus.valid = active_q && (state == ST_FETCH || state == ST_MEM);
	assign bus.addr  = (state == ST_MEM) ? operand : pc;
	assign bus.op    = (state == ST_MEM && opcode == OP_STORE) ? PI1_WRITE : PI1_READ;
	assign bus.wdata = acc;

	// a stalled request must not move, whatever the arbiter does meanwhile.
	a_req_stable: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		bus.valid && !bus.ready |=>
			bus.valid && $stable(bus.op) && $stable(bus.addr) && $stable(bus.wdata)
	) else $error("request changed before handshake");

endmodule

//--- hw/pi1_arb.sv
// ################################################
// round-robin arbiter merging the unit links onto
// the memory port. grant is held until handshake.
// ################################################

module pi1_arb import multipu_pkg::*; (
	input  logic              clk_i,
	input  logic              rst_n_i,
	pi1_if.slave              m [PU_COUNT],
	output logic              pi1_valid_o,
	input  logic              pi1_ready_i,
	output pi1_op_e           pi1_op_o,
	output logic [ADDR_W-1:0] pi1_addr_o,
	output logic [DATA_W-1:0] pi1_data_o,
	input  logic [DATA_W-1:0] pi1_data_i
);

	logic [PU_COUNT-1:0] req;
	logic [PU_COUNT-1:0] ready_v;
	pi1_op_e             op_a    [PU_COUNT];
	logic [ADDR_W-1:0]   addr_a  [PU_COUNT];
	logic [DATA_W-1:0]   wdata_a [PU_COUNT];
	logic [GRANT_W-1:0]  gnt_q;  // last winner, or current grant while locked.
	logic                lock_q;
	logic [GRANT_W-1:0]  pick;
	logic [GRANT_W-1:0]  sel;

	for (genvar i = 0; i < PU_COUNT; i++) begin : g_link
		assign req[i]     = m[i].valid;
		assign op_a[i]    = m[i].op;
		assign addr_a[i]  = m[i].addr;
		assign wdata_a[i] = m[i].wdata;

		assign ready_v[i]  = (sel == GRANT_W'(i)) && req[i] && pi1_ready_i;
		assign m[i].ready  = ready_v[i];
		assign m[i].rdata  = (sel == GRANT_W'(i)) ? pi1_data_i : '0;
	end

	// first requester after the last winner; the last winner itself comes last.
	always_comb begin : rr_pick
		int idx;
		pick = gnt_q;
		for (int k = PU_COUNT; k >= 1; k--) begin
			idx = (int'(gnt_q) + k) % PU_COUNT;
			if (req[idx]) begin
				pick = GRANT_W'(idx);
			end
		end
	end

	assign sel = lock_q ? gnt_q : pick;

	assign pi1_valid_o = req[sel];
	assign pi1_op_o    = op_a[sel];
	assign pi1_addr_o  = addr_a[sel];
	assign pi1_data_o  = wdata_a[sel];

	always_ff @(posedge clk_i or negedge rst_n_i) begin
		if (!rst_n_i) begin
			gnt_q  <= GRANT_W'(PU_COUNT - 1); // so unit 0 wins first.
			lock_q <= 1'b0;
		end else if (pi1_valid_o) begin
			gnt_q  <= sel;
			lock_q <= !pi1_ready_i;
		end
	end

	a_one_ready: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		$onehot0(ready_v)
	) else $error("more than one link sees ready");

	// a stalled transfer keeps its owner and stays on the port.
	a_grant_held: assert property (
		@(posedge clk_i) disable iff (!rst_n_i)
		pi1_valid_o && !pi1_ready_i |=> pi1_valid_o && sel == $past(sel)
	) else $error("grant moved before handshake");

endmodule

//--- hw/multipu.sv
// ################################################
// cluster top: PU_COUNT units behind one arbiter,
// memory reached over plain pi1 ports.
// ################################################

module multipu import multipu_pkg::*; (
	input  logic                clk_i,
	input  logic                rst_n_i,

	output logic                pi1_valid_o,
	input  logic                pi1_ready_i,
	output pi1_op_e             pi1_op_o,
	output logic [ADDR_W-1:0]   pi1_addr_o,
	output logic [DATA_W-1:0]   pi1_data_o,
	input  logic [DATA_W-1:0]   pi1_data_i,

	input  logic [ADDR_W-1:0]   rstaddr_i,
	input  logic [ADDR_W-1:0]   rstaddr2_i,
	output logic [PU_COUNT-1:0] halted_o
);

	pi1_if link [PU_COUNT] ();

	for (genvar i = 0; i < PU_COUNT; i++) begin : g_pu
		pu u_pu (
			.clk_i     (clk_i),
			.rst_n_i   (rst_n_i),
			.rstaddr_i ((i == 0) ? rstaddr_i : rstaddr2_i), // unit 0 alone uses rstaddr_i.
			.halted_o  (halted_o[i]),
			.bus       (link[i])
		);
	end

	pi1_arb u_arb (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.m           (link),
		.pi1_valid_o (pi1_valid_o),
		.pi1_ready_i (pi1_ready_i),
		.pi1_op_o    (pi1_op_o),
		.pi1_addr_o  (pi1_addr_o),
		.pi1_data_o  (pi1_data_o),
		.pi1_data_i  (pi1_data_i)
	);

endmodule

//--- dv/multipu_tb.sv
// ################################################
// cluster testbench: random programs per unit, a
// memory responder with back-pressure and a model.
// ################################################

module multipu_tb import multipu_pkg::*; ();

	localparam int SEED         = 85312;
	localparam int NTESTS       = 3;
	localparam int PROG_LEN     = 24; // random instructions before the halt.
	localparam int DATA_N       = 16; // data words per unit.
	localparam int MAX_TR       = 2 * (PROG_LEN + 1);
	localparam int RESET_CYCLES = 16;
	localparam int TOTAL_INSTR  = NTESTS * PU_COUNT * (PROG_LEN + 1);
	localparam int WD_CYCLES    = TOTAL_INSTR * PU_COUNT * 10 + NTESTS * (RESET_CYCLES + 8);

	logic                clk_i;
	logic                rst_n_i;
	logic                pi1_valid_o;
	logic                pi1_ready_i;
	pi1_op_e             pi1_op_o;
	logic [ADDR_W-1:0]   pi1_addr_o;
	logic [DATA_W-1:0]   pi1_data_o;
	logic [DATA_W-1:0]   pi1_data_i;
	logic [ADDR_W-1:0]   rstaddr_i;
	logic [ADDR_W-1:0]   rstaddr2_i;
	logic [PU_COUNT-1:0] halted_o;

	logic [DATA_W-1:0] mem [1 << ADDR_W];
	logic [DATA_W-1:0] exp_data [PU_COUNT][DATA_N]; // model view of each data region.
	logic [ADDR_W-1:0] prog_base [PU_COUNT];
	logic [ADDR_W-1:0] data_base [PU_COUNT];

	// expected bus transfers of each unit, in program order.
	bit                tr_fetch [PU_COUNT][MAX_TR];
	pi1_op_e           tr_op    [PU_COUNT][MAX_TR];
	logic [ADDR_W-1:0] tr_addr  [PU_COUNT][MAX_TR];
	logic [DATA_W-1:0] tr_data  [PU_COUNT][MAX_TR];
	int                tr_len   [PU_COUNT];
	int                tr_pos   [PU_COUNT];
	int                req_from [PU_COUNT]; // cycle from which the unit is requesting.
	int                waits    [PU_COUNT];
	int                halted_from [PU_COUNT]; // cycle from which halted_o is up.

	int                errors = 0;
	int                n_checks = 0;
	int                cyc;
	int                wait_left;
	bit                started = 1'b0;
	bit                pend;
	pi1_op_e           hold_op;
	logic [ADDR_W-1:0] hold_addr;
	logic [DATA_W-1:0] hold_data;

	multipu dut0 (
		.clk_i       (clk_i),
		.rst_n_i     (rst_n_i),
		.pi1_valid_o (pi1_valid_o),
		.pi1_ready_i (pi1_ready_i),
		.pi1_op_o    (pi1_op_o),
		.pi1_addr_o  (pi1_addr_o),
		.pi1_data_o  (pi1_data_o),
		.pi1_data_i  (pi1_data_i),
		.rstaddr_i   (rstaddr_i),
		.rstaddr2_i  (rstaddr2_i),
		.halted_o    (halted_o)
	);

	initial begin
		clk_i = 1'b0;
		forever #2 clk_i = ~clk_i;
	end

	task automatic check(string name, logic [31:0] got, logic [31:0] exp);
		n_checks++;
		if (got !== exp) begin
			errors++;
			$display("CHECK FAILED t=%0t %s got=%0h expected=%0h", $time, name, got, exp);
		end
	endtask

	task automatic report_error(string what);
		errors++;
		$display("ERROR t=%0t %s", $time, what);
	endtask

	task automatic add_transfer(int k, bit fetch, pi1_op_e op, logic [ADDR_W-1:0] a,
			logic [DATA_W-1:0] d);
		tr_fetch[k][tr_len[k]] = fetch;
		tr_op[k][tr_len[k]]    = op;
		tr_addr[k][tr_len[k]]  = a;
		tr_data[k][tr_len[k]]  = d;
		tr_len[k]++;
	endtask

	// fills memory, writes the programs and runs them through the model.
	task automatic build_test();
		int                idx;
		logic [DATA_W-1:0] acc;
		opcode_e           op;
		logic [ADDR_W-1:0] pc;
		logic [ADDR_W-1:0] opnd;
		for (int a = 0; a < (1 << ADDR_W); a++) begin
			mem[a] = {2'b10, ADDR_W'(a)};
		end
		for (int k = 0; k < PU_COUNT; k++) begin
			prog_base[k] = ADDR_W'(k * 'h800 + int'($urandom % 'h400));
			data_base[k] = ADDR_W'('h2000 + k * 'h100);
			for (int i = 0; i < DATA_N; i++) begin
				exp_data[k][i] = DATA_W'($urandom); // full range, so adds wrap often.
				mem[data_base[k] + ADDR_W'(i)] = exp_data[k][i];
			end
			acc = '0;
			tr_len[k] = 0;
			for (int i = 0; i <= PROG_LEN; i++) begin
				pc = prog_base[k] + ADDR_W'(i);
				idx = int'($urandom % DATA_N);
				opnd = data_base[k] + ADDR_W'(idx);
				op = (i == PROG_LEN) ? OP_HALT : opcode_e'(2'($urandom % 3));
				mem[pc] = {op, opnd};
				add_transfer(k, 1'b1, PI1_READ, pc, '0);
				case (op)
					OP_LOAD: begin
						acc = exp_data[k][idx];
						add_transfer(k, 1'b0, PI1_READ, opnd, '0);
					end
					OP_ADD: begin
						acc = acc + exp_data[k][idx];
						add_transfer(k, 1'b0, PI1_READ, opnd, '0);
					end
					OP_STORE: begin
						exp_data[k][idx] = acc;
						add_transfer(k, 1'b0, PI1_WRITE, opnd, acc);
					end
					default: begin
					end
				endcase
			end
		end
	endtask

	function automatic int unit_of(logic [ADDR_W-1:0] a);
		int u;
		u = -1;
		for (int k = 0; k < PU_COUNT; k++) begin
			if (a >= prog_base[k] && a <= prog_base[k] + ADDR_W'(PROG_LEN)) begin
				u = k;
			end
			if (a >= data_base[k] && a < data_base[k] + ADDR_W'(DATA_N)) begin
				u = k;
			end
		end
		return u;
	endfunction

	// one completed handshake, matched against the owning unit's next transfer.
	task automatic take_transfer();
		int u;
		int p;
		u = unit_of(pi1_addr_o);
		if (u < 0) begin
			report_error($sformatf("transfer to %0h lies outside every unit region", pi1_addr_o));
		end else if (tr_pos[u] >= tr_len[u]) begin
			report_error($sformatf("unit %0d made a transfer after its halt", u));
		end else begin
			p = tr_pos[u];
			check("pi1_op_o", 32'(pi1_op_o), 32'(tr_op[u][p]));
			check("pi1_addr_o", 32'(pi1_addr_o), 32'(tr_addr[u][p]));
			if (pi1_op_o == PI1_WRITE) begin
				check("pi1_data_o", 32'(pi1_data_o), 32'(tr_data[u][p]));
				mem[pi1_addr_o] = pi1_data_o;
			end
			for (int k = 0; k < PU_COUNT; k++) begin
				if (k != u && tr_pos[k] < tr_len[k] && cyc >= req_from[k]) begin
					waits[k]++;
					if (waits[k] > PU_COUNT - 1) begin
						report_error($sformatf("unit %0d passed over by %0d grants", k, waits[k]));
					end
				end
			end
			waits[u] = 0;
			req_from[u] = tr_fetch[u][p] ? cyc + 2 : cyc + 1; // decode cycle after a fetch.
			tr_pos[u] = p + 1;
			if (tr_pos[u] == tr_len[u]) begin
				halted_from[u] = cyc + 2; // halt decode, then ST_HALT.
			end
		end
	endtask

	task automatic watch_port();
		if (cyc == 0) begin
			check("pi1_valid_o", 32'(pi1_valid_o), 32'(0));
		end
		for (int k = 0; k < PU_COUNT; k++) begin
			check($sformatf("halted_o[%0d]", k), 32'(halted_o[k]),
				32'(tr_pos[k] == tr_len[k] && cyc >= halted_from[k]));
		end
		if (pend) begin
			check("pi1_valid_o", 32'(pi1_valid_o), 32'(1));
			check("pi1_op_o", 32'(pi1_op_o), 32'(hold_op));
			check("pi1_addr_o", 32'(pi1_addr_o), 32'(hold_addr));
			check("pi1_data_o", 32'(pi1_data_o), 32'(hold_data));
		end
		if (pi1_valid_o && pi1_ready_i) begin
			take_transfer();
			pend = 1'b0;
			pi1_ready_i <= 1'b0;
			wait_left = int'($urandom % 4);
		end else if (pi1_valid_o) begin
			pend = 1'b1;
			hold_op = pi1_op_o;
			hold_addr = pi1_addr_o;
			hold_data = pi1_data_o;
			if (wait_left == 0) begin
				pi1_ready_i <= 1'b1;
				pi1_data_i <= mem[pi1_addr_o];
			end else begin
				wait_left--;
			end
		end
	endtask

	// memory responder and port monitor.
	always @(posedge clk_i) begin
		if (!rst_n_i) begin
			started = 1'b1;
			pi1_ready_i <= 1'b0;
			cyc = 0;
			pend = 1'b0;
			wait_left = int'($urandom % 4);
			for (int k = 0; k < PU_COUNT; k++) begin
				tr_pos[k] = 0;
				req_from[k] = 1; // the first fetch follows reset release by a cycle.
				waits[k] = 0;
				halted_from[k] = 0;
			end
			check("pi1_valid_o", 32'(pi1_valid_o), 32'(0));
			check("halted_o", 32'(halted_o), 32'(0));
		end else if (started) begin
			watch_port();
			cyc++;
		end
	end

	initial begin
		repeat (WD_CYCLES) @(posedge clk_i);
		$display("watchdog: units did not all halt within %0d cycles", WD_CYCLES);
		$display("Testbench failed");
		$finish;
	end

	initial begin
		int err_before;
		int n_xfer;
		void'($urandom(SEED));
		rst_n_i = 1'b1;
		pi1_ready_i = 1'b0;
		pi1_data_i = '0;
		rstaddr_i = '0;
		rstaddr2_i = '0;
		for (int t = 0; t < NTESTS; t++) begin
			err_before = errors;
			build_test();
			@(posedge clk_i);
			rstaddr_i <= prog_base[0];
			rstaddr2_i <= prog_base[1];
			@(posedge clk_i);
			rst_n_i <= 1'b0;
			repeat (RESET_CYCLES) @(posedge clk_i);
			rst_n_i <= 1'b1;
			while (halted_o !== {PU_COUNT{1'b1}}) begin
				@(posedge clk_i);
			end
			repeat (4) @(posedge clk_i); // halted_o has to stay up.
			n_xfer = 0;
			for (int k = 0; k < PU_COUNT; k++) begin
				n_xfer += tr_pos[k];
				if (tr_pos[k] != tr_len[k]) begin
					report_error($sformatf("unit %0d made %0d of %0d transfers",
						k, tr_pos[k], tr_len[k]));
				end
				for (int i = 0; i < DATA_N; i++) begin
					check($sformatf("mem[%0h]", data_base[k] + ADDR_W'(i)),
						32'(mem[data_base[k] + ADDR_W'(i)]), 32'(exp_data[k][i]));
				end
			end
			$display("test %0d done: %0d transfers, %0d errors", t, n_xfer, errors - err_before);
		end
		$display("%0d tests, %0d checks, %0d errors", NTESTS, n_checks, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

//--- multipu.f
hw/multipu_pkg.sv
hw/pi1_if.sv
hw/pu_ctrl.sv
hw/pu_pc.sv
hw/pu_alu.sv
hw/pu.sv
hw/pi1_arb.sv
hw/multipu.sv
dv/multipu_tb.sv

//--- run.sh
#!/bin/sh
# compile the cluster testbench with Verilator, run it and scan the log.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal -j 0 \
	--top-module multipu_tb -f multipu.f

status=0
./obj_dir/Vmultipu_tb > sim.log 2>&1 || status=$?
cat sim.log

if grep -q "Testbench failed" sim.log; then
	exit 1
fi
if [ "$status" -ne 0 ]; then
	echo "simulation exited with status $status"
	exit "$status"
fi
exit 0
